/* core_macros.svh */
`ifndef CORE_MACROS_SVH
`define CORE_MACROS_SVH

// Data path and address width
`define CORE_XLEN     32
`define CORE_ILEN     32
`define CORE_REG_AW   5

// First fetch address after reset
`define CORE_RESET_PC 32'h0000_0000

`endif

/* core_pkg.sv */
`include "core_macros.svh"

package core_pkg;

    typedef logic [`CORE_XLEN-1:0]   word_t;
    typedef logic [`CORE_XLEN-1:0]   addr_t;
    typedef logic [`CORE_ILEN-1:0]   instr_t;
    typedef logic [`CORE_REG_AW-1:0] reg_idx_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_PASSB
    } alu_op_e;

    typedef enum logic [1:0] {
        MEM_NONE,
        MEM_LOAD,
        MEM_STORE
    } mem_op_e;

    // Encoded as on the data port
    typedef enum logic [1:0] {
        SZ_BYTE = 2'd0,
        SZ_HALF = 2'd1,
        SZ_WORD = 2'd2
    } mem_size_e;

    typedef enum logic [1:0] {
        F_REQ,
        F_WAIT,
        F_HOLD
    } fetch_state_e;

    typedef enum logic [1:0] {
        M_IDLE,
        M_WAIT,
        M_DONE
    } mem_state_e;

endpackage

/* core_ifs.sv */
`timescale 1ns/10ps

// Fetch to decode
interface stage_if_id_if;
    logic                give;
    logic                get;
    core_pkg::instr_t    instr;

    modport giver (output give, instr, input get);
    modport taker (input give, instr, output get);
endinterface

// Decode to execute
interface id_ex_if;
    logic                  give;
    logic                  get;
    core_pkg::alu_op_e     alu_op;
    core_pkg::mem_op_e     mem_op;
    core_pkg::mem_size_e   mem_size;
    core_pkg::reg_idx_t    rd;
    logic                  rd_en;
    core_pkg::word_t       op_a;
    core_pkg::word_t       op_b;
    core_pkg::word_t       store_data;

    modport giver (output give, alu_op, mem_op, mem_size, rd, rd_en, op_a, op_b, store_data,
                   input get);
    modport taker (input give, alu_op, mem_op, mem_size, rd, rd_en, op_a, op_b, store_data,
                   output get);
endinterface

// Execute to memory/writeback
interface ex_mem_if;
    logic                  give;
    logic                  get;
    core_pkg::mem_op_e     mem_op;
    core_pkg::mem_size_e   mem_size;
    core_pkg::reg_idx_t    rd;
    logic                  rd_en;
    core_pkg::word_t       result;
    core_pkg::word_t       store_data;

    modport giver (output give, mem_op, mem_size, rd, rd_en, result, store_data, input get);
    modport taker (input give, mem_op, mem_size, rd, rd_en, result, store_data, output get);
endinterface

// Request held until valid
interface mem_port_if;
    core_pkg::addr_t       addr;
    core_pkg::word_t       wdata;
    core_pkg::word_t       rdata;
    logic                  read;
    logic                  write;
    core_pkg::mem_size_e   size;
    logic                  valid;

    modport master (output addr, wdata, read, write, size, input rdata, valid);
    modport slave  (input addr, wdata, read, write, size, output rdata, valid);
endinterface

/* register_file.sv */
`timescale 1ns/10ps
`include "core_macros.svh"

module register_file
(
    input  logic                  clk,
    input  logic                  arst_n_i,
    input  logic                  we_i,
    input  core_pkg::reg_idx_t    rd_i,
    input  core_pkg::word_t       rd_data_i,
    input  core_pkg::reg_idx_t    rs1_i,
    input  core_pkg::reg_idx_t    rs2_i,
    output core_pkg::word_t       rs1_data_o,
    output core_pkg::word_t       rs2_data_o
);

// No storage behind x0
core_pkg::word_t regs_q [1:(2**`CORE_REG_AW)-1];

always_ff @(posedge clk or negedge arst_n_i)
begin
    if (!arst_n_i)
    begin
        for (int i = 1; i < 2**`CORE_REG_AW; i++)
            regs_q[i] <= '0;
    end
    else if (we_i && rd_i != '0)
        regs_q[rd_i] <= rd_data_i;
end

assign rs1_data_o = (rs1_i == '0) ? '0 : regs_q[rs1_i];
assign rs2_data_o = (rs2_i == '0) ? '0 : regs_q[rs2_i];

endmodule

/* fetch_stage.sv */
`timescale 1ns/10ps
`include "core_macros.svh"

module fetch_stage
(
    input  logic                  clk,
    input  logic                  arst_n_i,
    input  logic                  halt_i,
    stage_if_id_if.giver          to_id,
    mem_port_if.master            imem
);

core_pkg::fetch_state_e state_q;
core_pkg::addr_t        pc_q;

// Read-only port
assign imem.addr  = pc_q;
assign imem.wdata = '0;
assign imem.write = 1'b0;
assign imem.size  = core_pkg::SZ_WORD;

always_ff @(posedge clk or negedge arst_n_i)
begin
    if (!arst_n_i)
    begin
        state_q    <= core_pkg::F_REQ;
        pc_q       <= `CORE_RESET_PC;
        imem.read  <= 1'b0;
        to_id.give <= 1'b0;
    end
    else
    begin
        case (state_q)
            core_pkg::F_REQ:
            begin
                if (!halt_i)
                begin
                    imem.read <= 1'b1;
                    state_q   <= core_pkg::F_WAIT;
                end
            end
            core_pkg::F_WAIT:
            begin
                if (imem.valid)
                begin
                    imem.read  <= 1'b0;
                    to_id.give <= 1'b1;
                    pc_q       <= pc_q + 32'd4;
                    state_q    <= core_pkg::F_HOLD;
                end
            end
            core_pkg::F_HOLD:
            begin
                // Wait for decode to take the word
                if (to_id.get)
                begin
                    to_id.give <= 1'b0;
                    state_q    <= core_pkg::F_REQ;
                end
            end
            default:
                state_q <= core_pkg::F_REQ;
        endcase
    end
end

always_ff @(posedge clk)
begin
    if (state_q == core_pkg::F_WAIT && imem.valid)
        to_id.instr <= imem.rdata;
end

endmodule

/* decode_stage.sv */
`timescale 1ns/10ps
`include "core_macros.svh"

module decode_stage
(
    input  logic                  clk,
    input  logic                  arst_n_i,
    stage_if_id_if.taker          from_if,
    id_ex_if.giver                to_ex,
    output core_pkg::reg_idx_t    rs1_o,
    output core_pkg::reg_idx_t    rs2_o,
    input  core_pkg::word_t       rs1_data_i,
    input  core_pkg::word_t       rs2_data_i,
    input  logic                  wb_we_i,
    input  core_pkg::reg_idx_t    wb_rd_i,
    output logic                  inv_instr_o
);

core_pkg::instr_t       instr;
core_pkg::reg_idx_t     rd;
logic [6:0]             opcode;
logic [2:0]             funct3;
logic [6:0]             funct7;
core_pkg::word_t        imm_i;
core_pkg::word_t        imm_s;
core_pkg::word_t        imm_u;
core_pkg::word_t        imm;
core_pkg::alu_op_e      alu_op;
core_pkg::mem_op_e      mem_op;
core_pkg::mem_size_e    mem_size;
logic                   illegal;
logic                   uses_rs1;
logic                   uses_rs2;
logic                   writes_rd;
logic                   use_imm;
logic                   dest_en;
logic                   hazard;
logic                   take;
logic                   inv_q;
logic [(2**`CORE_REG_AW)-1:0] busy_q;

assign instr  = from_if.instr;
assign opcode = instr[6:0];
assign rd     = instr[11:7];
assign funct3 = instr[14:12];
assign rs1_o  = instr[19:15];
assign rs2_o  = instr[24:20];
assign funct7 = instr[31:25];

assign imm_i = {{20{instr[31]}}, instr[31:20]};
assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
assign imm_u = {instr[31:12], 12'b0};

always_comb
begin
    illegal   = 1'b0;
    uses_rs1  = 1'b1;
    uses_rs2  = 1'b0;
    writes_rd = 1'b1;
    use_imm   = 1'b1;
    imm       = imm_i;
    alu_op    = core_pkg::ALU_ADD;
    mem_op    = core_pkg::MEM_NONE;
    mem_size  = core_pkg::SZ_WORD;
    case (opcode)
        7'b0110111:
        begin
            uses_rs1 = 1'b0;
            imm      = imm_u;
            alu_op   = core_pkg::ALU_PASSB;
        end
        7'b0010011:
        begin
            case (funct3)
                3'b000:  alu_op = core_pkg::ALU_ADD;
                3'b010:  alu_op = core_pkg::ALU_SLT;
                3'b100:  alu_op = core_pkg::ALU_XOR;
                3'b110:  alu_op = core_pkg::ALU_OR;
                3'b111:  alu_op = core_pkg::ALU_AND;
                default: illegal = 1'b1;
            endcase
        end
        7'b0110011:
        begin
            uses_rs2 = 1'b1;
            use_imm  = 1'b0;
            case ({funct7, funct3})
                10'b0000000_000: alu_op = core_pkg::ALU_ADD;
                10'b0100000_000: alu_op = core_pkg::ALU_SUB;
                10'b0000000_010: alu_op = core_pkg::ALU_SLT;
                10'b0000000_100: alu_op = core_pkg::ALU_XOR;
                10'b0000000_110: alu_op = core_pkg::ALU_OR;
                10'b0000000_111: alu_op = core_pkg::ALU_AND;
                default:         illegal = 1'b1;
            endcase
        end
        7'b0000011:
        begin
            // LW only
            mem_op  = core_pkg::MEM_LOAD;
            illegal = (funct3 != 3'b010);
        end
        7'b0100011:
        begin
            uses_rs2  = 1'b1;
            writes_rd = 1'b0;
            imm       = imm_s;
            mem_op    = core_pkg::MEM_STORE;
            if (funct3 == 3'b000)
                mem_size = core_pkg::SZ_BYTE;
            else if (funct3 != 3'b010)
                illegal = 1'b1;
        end
        default:
            illegal = 1'b1;
    endcase
end

assign dest_en = writes_rd && (rd != '0);

// Sources and destination must have no write pending
assign hazard = (uses_rs1 && busy_q[rs1_o]) || (uses_rs2 && busy_q[rs2_o])
             || (dest_en && busy_q[rd]);

assign from_if.get = (!to_ex.give || to_ex.get) && (illegal || !hazard);
assign take        = from_if.give && from_if.get;
assign inv_instr_o = inv_q;

always_ff @(posedge clk or negedge arst_n_i)
begin
    if (!arst_n_i)
    begin
        busy_q     <= '0;
        inv_q      <= 1'b0;
        to_ex.give <= 1'b0;
    end
    else
    begin
        if (wb_we_i)
            busy_q[wb_rd_i] <= 1'b0;
        if (take && !illegal && dest_en)
            busy_q[rd] <= 1'b1;
        if (take && illegal)
            inv_q <= 1'b1;
        if (to_ex.get)
            to_ex.give <= 1'b0;
        if (take && !illegal)
            to_ex.give <= 1'b1;
    end
end

always_ff @(posedge clk)
begin
    if (take)
    begin
        to_ex.alu_op     <= alu_op;
        to_ex.mem_op     <= mem_op;
        to_ex.mem_size   <= mem_size;
        to_ex.rd         <= rd;
        to_ex.rd_en      <= dest_en;
        to_ex.op_a       <= rs1_data_i;
        to_ex.op_b       <= use_imm ? imm : rs2_data_i;
        to_ex.store_data <= rs2_data_i;
    end
end

endmodule

/* execute_stage.sv */
`timescale 1ns/10ps

module execute_stage
(
    input  logic          clk,
    input  logic          arst_n_i,
    id_ex_if.taker        from_id,
    ex_mem_if.giver       to_mem
);

logic            take;
core_pkg::word_t alu_res;

assign from_id.get = !to_mem.give || to_mem.get;
assign take        = from_id.give && from_id.get;

// Loads and stores come in as ALU_ADD for the effective address
always_comb
begin
    alu_res = '0;
    case (from_id.alu_op)
        core_pkg::ALU_ADD:   alu_res = from_id.op_a + from_id.op_b;
        core_pkg::ALU_SUB:   alu_res = from_id.op_a - from_id.op_b;
        core_pkg::ALU_AND:   alu_res = from_id.op_a & from_id.op_b;
        core_pkg::ALU_OR:    alu_res = from_id.op_a | from_id.op_b;
        core_pkg::ALU_XOR:   alu_res = from_id.op_a ^ from_id.op_b;
        core_pkg::ALU_SLT:   alu_res[0] = $signed(from_id.op_a) < $signed(from_id.op_b);
        core_pkg::ALU_PASSB: alu_res = from_id.op_b;
        default:             alu_res = '0;
    endcase
end

always_ff @(posedge clk or negedge arst_n_i)
begin
    if (!arst_n_i)
        to_mem.give <= 1'b0;
    else if (take)
        to_mem.give <= 1'b1;
    else if (to_mem.get)
        to_mem.give <= 1'b0;
end

always_ff @(posedge clk)
begin
    if (take)
    begin
        to_mem.mem_op     <= from_id.mem_op;
        to_mem.mem_size   <= from_id.mem_size;
        to_mem.rd         <= from_id.rd;
        to_mem.rd_en      <= from_id.rd_en;
        to_mem.result     <= alu_res;
        to_mem.store_data <= from_id.store_data;
    end
end

endmodule

/* mem_wb_stage.sv */
`timescale 1ns/10ps

module mem_wb_stage
(
    input  logic                  clk,
    input  logic                  arst_n_i,
    ex_mem_if.taker               from_ex,
    mem_port_if.master            dmem,
    output logic                  rf_we_o,
    output core_pkg::reg_idx_t    rf_rd_o,
    output core_pkg::word_t       rf_data_o
);

core_pkg::mem_state_e state_q;
logic                 take;
logic                 wb_en_q;
logic                 done;

assign from_ex.get = (state_q != core_pkg::M_WAIT);
assign take        = from_ex.give && from_ex.get;
assign done        = (state_q == core_pkg::M_WAIT) && dmem.valid;

always_ff @(posedge clk or negedge arst_n_i)
begin
    if (!arst_n_i)
    begin
        state_q    <= core_pkg::M_IDLE;
        dmem.read  <= 1'b0;
        dmem.write <= 1'b0;
        rf_we_o    <= 1'b0;
    end
    else
    begin
        rf_we_o <= 1'b0;
        case (state_q)
            core_pkg::M_WAIT:
            begin
                if (dmem.valid)
                begin
                    dmem.read  <= 1'b0;
                    dmem.write <= 1'b0;
                    rf_we_o    <= dmem.read && wb_en_q;
                    state_q    <= core_pkg::M_DONE;
                end
            end
            default:
            begin
                // Idle, or the write-back cycle of the last access
                state_q <= core_pkg::M_IDLE;
                if (take)
                begin
                    if (from_ex.mem_op == core_pkg::MEM_NONE)
                        rf_we_o <= from_ex.rd_en;
                    else
                    begin
                        dmem.read  <= (from_ex.mem_op == core_pkg::MEM_LOAD);
                        dmem.write <= (from_ex.mem_op == core_pkg::MEM_STORE);
                        state_q    <= core_pkg::M_WAIT;
                    end
                end
            end
        endcase
    end
end

always_ff @(posedge clk)
begin
    if (take)
    begin
        rf_rd_o    <= from_ex.rd;
        rf_data_o  <= from_ex.result;
        wb_en_q    <= from_ex.rd_en;
        dmem.addr  <= from_ex.result;
        dmem.size  <= from_ex.mem_size;
        // Byte store goes out on the low lane
        if (from_ex.mem_size == core_pkg::SZ_BYTE)
            dmem.wdata <= {24'b0, from_ex.store_data[7:0]};
        else
            dmem.wdata <= from_ex.store_data;
    end
    else if (done)
        rf_data_o <= dmem.rdata;
end

endmodule

/* core_top.sv */
`timescale 1ns/10ps

module core_top
(
    input  logic                  clk,
    input  logic                  arst_n_i,
    // Instruction memory
    output core_pkg::addr_t       imem_addr_o,
    output logic                  imem_read_o,
    input  core_pkg::instr_t      imem_rdata_i,
    input  logic                  imem_valid_i,
    // Data memory
    output core_pkg::addr_t       dmem_addr_o,
    output core_pkg::word_t       dmem_wdata_o,
    input  core_pkg::word_t       dmem_rdata_i,
    output logic                  dmem_read_o,
    output logic                  dmem_write_o,
    output logic [1:0]            dmem_size_o,
    input  logic                  dmem_valid_i,
    output logic                  inv_instr_o
);

stage_if_id_if  if_id ();
id_ex_if        id_ex ();
ex_mem_if       ex_mem ();
mem_port_if     imem ();
mem_port_if     dmem ();

core_pkg::reg_idx_t rs1;
core_pkg::reg_idx_t rs2;
core_pkg::word_t    rs1_data;
core_pkg::word_t    rs2_data;
logic               rf_we;
core_pkg::reg_idx_t rf_rd;
core_pkg::word_t    rf_data;

assign imem_addr_o  = imem.addr;
assign imem_read_o  = imem.read;
assign imem.rdata   = imem_rdata_i;
assign imem.valid   = imem_valid_i;

assign dmem_addr_o  = dmem.addr;
assign dmem_wdata_o = dmem.wdata;
assign dmem_read_o  = dmem.read;
assign dmem_write_o = dmem.write;
assign dmem_size_o  = dmem.size;
assign dmem.rdata   = dmem_rdata_i;
assign dmem.valid   = dmem_valid_i;

register_file register_file_i (
    .clk        (   clk         ),
    .arst_n_i   (   arst_n_i    ),
    .we_i       (   rf_we       ),
    .rd_i       (   rf_rd       ),
    .rd_data_i  (   rf_data     ),
    .rs1_i      (   rs1         ),
    .rs2_i      (   rs2         ),
    .rs1_data_o (   rs1_data    ),
    .rs2_data_o (   rs2_data    )
);

fetch_stage fetch_stage_i (
    .clk        (   clk         ),
    .arst_n_i   (   arst_n_i    ),
    .halt_i     (   inv_instr_o ),
    .to_id      (   if_id       ),
    .imem       (   imem        )
);

decode_stage decode_stage_i (
    .clk         (   clk         ),
    .arst_n_i    (   arst_n_i    ),
    .from_if     (   if_id       ),
    .to_ex       (   id_ex       ),
    .rs1_o       (   rs1         ),
    .rs2_o       (   rs2         ),
    .rs1_data_i  (   rs1_data    ),
    .rs2_data_i  (   rs2_data    ),
    .wb_we_i     (   rf_we       ),
    .wb_rd_i     (   rf_rd       ),
    .inv_instr_o (   inv_instr_o )
);

execute_stage execute_stage_i (
    .clk        (   clk         ),
    .arst_n_i   (   arst_n_i    ),
    .from_id    (   id_ex       ),
    .to_mem     (   ex_mem      )
);

mem_wb_stage mem_wb_stage_i (
    .clk        (   clk         ),
    .arst_n_i   (   arst_n_i    ),
    .from_ex    (   ex_mem      ),
    .dmem       (   dmem        ),
    .rf_we_o    (   rf_we       ),
    .rf_rd_o    (   rf_rd       ),
    .rf_data_o  (   rf_data     )
);

endmodule

/* tb_core_props.sv */
`timescale 1ns/10ps

module tb_core_props
(
    input  logic                  clk,
    input  logic                  arst_n_i,
    input  core_pkg::addr_t       imem_addr_i,
    input  logic                  imem_read_i,
    input  logic                  imem_valid_i,
    input  core_pkg::addr_t       dmem_addr_i,
    input  logic                  dmem_read_i,
    input  logic                  dmem_write_i,
    input  logic                  dmem_valid_i,
    input  logic                  inv_instr_i
);

int unsigned error_count = 0;

no_read_write: assert property (@(posedge clk) disable iff (!arst_n_i)
    !(dmem_read_i && dmem_write_i))
else
begin
    error_count++;
    $error("data port read and write high in the same cycle");
end

// Address held while the request waits
dmem_addr_stable: assert property (@(posedge clk) disable iff (!arst_n_i)
    (dmem_read_i || dmem_write_i) && !dmem_valid_i |=> $stable(dmem_addr_i))
else
begin
    error_count++;
    $error("data address changed while waiting for valid");
end

imem_addr_stable: assert property (@(posedge clk) disable iff (!arst_n_i)
    imem_read_i && !imem_valid_i |=> $stable(imem_addr_i))
else
begin
    error_count++;
    $error("instruction address changed while waiting for valid");
end

inv_sticky: assert property (@(posedge clk) disable iff (!arst_n_i)
    inv_instr_i |=> inv_instr_i)
else
begin
    error_count++;
    $error("invalid instruction flag fell after being set");
end

endmodule

/* tb_core.sv */
`timescale 1ns/10ps
`include "core_macros.svh"

module tb_core;

localparam int CLK_PERIOD  = 8;
localparam int MEM_WORDS   = 64;
localparam int TRACE_WORDS = 256;
// Word offsets inside the trace image
localparam int PROG_BASE   = 'h10;
localparam int DATA_BASE   = 'h50;
localparam int STORE_BASE  = 'h60;

logic                  clk;
logic                  arst_n_i;
core_pkg::addr_t       imem_addr_o;
logic                  imem_read_o;
core_pkg::instr_t      imem_rdata_i;
logic                  imem_valid_i;
core_pkg::addr_t       dmem_addr_o;
core_pkg::word_t       dmem_wdata_o;
core_pkg::word_t       dmem_rdata_i;
logic                  dmem_read_o;
logic                  dmem_write_o;
logic [1:0]            dmem_size_o;
logic                  dmem_valid_i;
logic                  inv_instr_o;

logic [`CORE_XLEN-1:0] trace_mem [0:TRACE_WORDS-1];
logic [`CORE_ILEN-1:0] imem [0:MEM_WORDS-1];
logic [7:0]            dmem [0:4*MEM_WORDS-1];

int     n_prog;
int     n_store;
int     n_data;
int     store_idx;
integer seed;
logic   trace_loaded;

core_top UUT (
    .clk          (   clk           ),
    .arst_n_i     (   arst_n_i      ),
    .imem_addr_o  (   imem_addr_o   ),
    .imem_read_o  (   imem_read_o   ),
    .imem_rdata_i (   imem_rdata_i  ),
    .imem_valid_i (   imem_valid_i  ),
    .dmem_addr_o  (   dmem_addr_o   ),
    .dmem_wdata_o (   dmem_wdata_o  ),
    .dmem_rdata_i (   dmem_rdata_i  ),
    .dmem_read_o  (   dmem_read_o   ),
    .dmem_write_o (   dmem_write_o  ),
    .dmem_size_o  (   dmem_size_o   ),
    .dmem_valid_i (   dmem_valid_i  ),
    .inv_instr_o  (   inv_instr_o   )
);

bind core_top tb_core_props props_i (
    .clk          (   clk           ),
    .arst_n_i     (   arst_n_i      ),
    .imem_addr_i  (   imem_addr_o   ),
    .imem_read_i  (   imem_read_o   ),
    .imem_valid_i (   imem_valid_i  ),
    .dmem_addr_i  (   dmem_addr_o   ),
    .dmem_read_i  (   dmem_read_o   ),
    .dmem_write_i (   dmem_write_o  ),
    .dmem_valid_i (   dmem_valid_i  ),
    .inv_instr_i  (   inv_instr_o   )
);

initial
begin
    clk = 1'b0;
    forever #(CLK_PERIOD/2) clk = ~clk;
end

task automatic stop_with_failure;
    $display("Simulation finished: FAIL");
    $fatal(1, "run stopped at the first error");
endtask

task automatic check_value(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
    if (actual !== expected)
    begin
        $display("mismatch %s: expected %h, actual %h", name, expected, actual);
        stop_with_failure();
    end
endtask

task automatic load_trace;
    for (int i = 0; i < MEM_WORDS; i++)
        imem[i] = '0;
    for (int i = 0; i < 4*MEM_WORDS; i++)
        dmem[i] = '0;
    $readmemh("core_trace.txt", trace_mem);
    n_prog  = int'(trace_mem[0]);
    n_store = int'(trace_mem[1]);
    n_data  = int'(trace_mem[2]);
    if (n_prog > DATA_BASE - PROG_BASE || n_data > STORE_BASE - DATA_BASE
        || n_store > (TRACE_WORDS - STORE_BASE) / 3)
    begin
        $display("trace file counts do not fit the trace layout");
        stop_with_failure();
    end
    for (int i = 0; i < n_prog; i++)
        imem[i] = trace_mem[PROG_BASE+i];
    // Little-endian byte lanes
    for (int i = 0; i < n_data; i++)
        for (int b = 0; b < 4; b++)
            dmem[4*i+b] = trace_mem[DATA_BASE+i][8*b +: 8];
endtask

task automatic check_store;
    int base;
    base = STORE_BASE + 3*store_idx;
    if (store_idx >= n_store)
    begin
        $display("unexpected store to %h after the last expected store", dmem_addr_o);
        stop_with_failure();
    end
    check_value($sformatf("store %0d address", store_idx), trace_mem[base], dmem_addr_o);
    check_value($sformatf("store %0d size", store_idx), trace_mem[base+1],
                32'(dmem_size_o));
    check_value($sformatf("store %0d data", store_idx), trace_mem[base+2], dmem_wdata_o);
    store_idx++;
endtask

// Instruction memory with 0 to 3 idle cycles per request
initial
begin : imem_model
    int wait_cycles;
    forever
    begin
        @(negedge clk);
        imem_valid_i = 1'b0;
        if (arst_n_i && imem_read_o)
        begin
            wait_cycles = $unsigned($random(seed)) % 4;
            repeat (wait_cycles) @(negedge clk);
            if (imem_addr_o >= 32'(4*MEM_WORDS))
            begin
                $display("instruction fetch outside the memory model at %h", imem_addr_o);
                stop_with_failure();
            end
            imem_rdata_i = imem[imem_addr_o[7:2]];
            imem_valid_i = 1'b1;
        end
    end
end

initial
begin : dmem_model
    int wait_cycles;
    int addr;
    int base;
    forever
    begin
        @(negedge clk);
        dmem_valid_i = 1'b0;
        if (arst_n_i && (dmem_read_o || dmem_write_o))
        begin
            wait_cycles = $unsigned($random(seed)) % 4;
            repeat (wait_cycles) @(negedge clk);
            if (dmem_addr_o >= 32'(4*MEM_WORDS))
            begin
                $display("data access outside the memory model at %h", dmem_addr_o);
                stop_with_failure();
            end
            addr = int'(dmem_addr_o);
            base = int'({dmem_addr_o[7:2], 2'b00});
            if (dmem_write_o)
            begin
                check_store();
                case (dmem_size_o)
                    2'd0:
                        dmem[addr] = dmem_wdata_o[7:0];
                    default:
                        for (int b = 0; b < 4; b++)
                            dmem[base+b] = dmem_wdata_o[8*b +: 8];
                endcase
            end
            else
                dmem_rdata_i = {dmem[base+3], dmem[base+2], dmem[base+1], dmem[base]};
            dmem_valid_i = 1'b1;
        end
    end
end

initial
begin : watchdog
    int limit;
    wait (trace_loaded === 1'b1);
    limit = 40*n_prog + 200;
    repeat (limit) @(posedge clk);
    $display("timeout: the core did not finish the program within %0d cycles", limit);
    stop_with_failure();
end

initial
begin : main_flow
    arst_n_i     = 1'b0;
    imem_rdata_i = '0;
    imem_valid_i = 1'b0;
    dmem_rdata_i = '0;
    dmem_valid_i = 1'b0;
    seed         = 32'he4bb4a61;
    store_idx    = 0;
    trace_loaded = 1'b0;
    load_trace();
    trace_loaded = 1'b1;

    repeat (5) @(negedge clk);
    check_value("reset imem_read_o", 32'd0, 32'(imem_read_o));
    check_value("reset dmem_read_o", 32'd0, 32'(dmem_read_o));
    check_value("reset dmem_write_o", 32'd0, 32'(dmem_write_o));
    check_value("reset inv_instr_o", 32'd0, 32'(inv_instr_o));
    arst_n_i = 1'b1;

    @(negedge clk);
    check_value("first fetch request", 32'd1, 32'(imem_read_o));

    // Trailing zero word ends the program
    wait (inv_instr_o === 1'b1);
    wait (store_idx == n_store);

    // Fetch must stay quiet once halted
    repeat (20)
    begin
        @(negedge clk);
        check_value("imem_read_o after halt", 32'd0, 32'(imem_read_o));
    end

    if (UUT.props_i.error_count == 0)
    begin
        $display("Simulation finished: PASS");
        $finish;
    end
    else
    begin
        $display("%0d assertion failures in the bound checker", UUT.props_i.error_count);
        stop_with_failure();
    end
end

endmodule

/* core_trace.txt */
// Words 00 to 02: program word count, expected store count, initial data word count
// @10 program words, @50 data words from address 0, @60 stores as address, size, data
@00
0000001C 0000000B 00000002
@10
123450B7 67808093 04102023 FFB00113
001121B3 40208233 001242B3 00227333
0F02E393 04302223 04402423 04502623
04602823 04702A23 FFF3C413 7FF47493
70B4A513 009505B3 04B02C23 00402603
00160693 04D02E23 04802703 06E00023
061000A3 06002783 06F02223 00000000
@50
0BADF00D CAFEF00D
@60
00000040 00000002 12345678
00000044 00000002 00000001
00000048 00000002 1234567D
0000004C 00000002 00000005
00000050 00000002 12345679
00000054 00000002 000000F5
00000058 00000002 0000070B
0000005C 00000002 CAFEF00E
00000060 00000000 0000007D
00000061 00000000 00000078
00000064 00000002 0000787D

/* all.f */
+incdir+.
core_pkg.sv
core_ifs.sv
register_file.sv
fetch_stage.sv
decode_stage.sv
execute_stage.sv
mem_wb_stage.sv
core_top.sv
tb_core_props.sv
tb_core.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_core -f all.f -o tb_core_sim

out=$(./obj_dir/tb_core_sim +verilator+error+limit+100 2>&1) || true
echo "$out"

if echo "$out" | grep -qx "Simulation finished: PASS"
then
    exit 0
fi
exit 1
